// File: verilog/memPkg.sv
package memPkg;

    // Basic datapath widths
    typedef logic [31:0] word_t;              // Data, address or instruction word
    typedef logic [3:0]  memOp_t;             // Memory op from the decoder
    typedef logic [1:0]  busCmd_t;            // Bus command, rwi

    // Load opcodes
    localparam memOp_t MemOpLb  = 4'd1;       // Byte, sign-extended
    localparam memOp_t MemOpLh  = 4'd2;       // Half-word, sign-extended
    localparam memOp_t MemOpLw  = 4'd3;       // Full word
    localparam memOp_t MemOpLbu = 4'd4;       // Byte, zero-extended
    localparam memOp_t MemOpLhu = 4'd5;       // Half-word, zero-extended

    // Store opcodes
    localparam memOp_t MemOpSb = 4'd6;        // Store low byte
    localparam memOp_t MemOpSh = 4'd7;        // Store low half-word
    localparam memOp_t MemOpSw = 4'd8;        // Store whole word

    // Bus commands
    localparam busCmd_t RwiIdle  = 2'b00;
    localparam busCmd_t RwiWrite = 2'b01;
    localparam busCmd_t RwiRead  = 2'b10;
    localparam busCmd_t RwiFetch = 2'b11;

    // Scratchpad geometry and timing
    localparam int MemDepthWords = 64;        // Indexed by address bits 7:2
    localparam int MemLatency    = 3;         // Busy cycles per request

    typedef logic [$clog2(MemDepthWords)-1:0] wordIndex_t; // Word slot in the scratchpad
    typedef logic [$clog2(MemLatency+1)-1:0]  latCount_t;  // Busy down-counter

    // Two-phase access sequencer
    typedef enum logic [1:0] {
        Fetch     = 2'd0,                     // Issue instruction fetch
        FetchWait = 2'd1,                     // Wait for fetch to finish
        Data      = 2'd2,                     // Issue load/store if asked
        DataWait  = 2'd3                      // Wait for data access
    } accessState_t;

    // One bus request as seen by the memory
    typedef struct packed {
        busCmd_t cmd;                         // rwi
        word_t   address;                     // Byte address, bits 1:0 ignored
        word_t   writeData;                   // Zero-extended store data
    } busRequest_t;

endpackage

// File: verilog/memAccessFsm.sv
module memAccessFsm import memPkg::*; (
    input  logic         clk,
    input  logic         nrst,
    input  logic         busy,                // Memory still working
    input  logic         memRead,             // Instruction is a load
    input  logic         memWrite,            // Instruction is a store
    output logic         reqStrobe,           // One-cycle request to the buffer
    output logic         addrControl,         // 0 fetch addr, 1 ALU addr
    output logic         freeze,              // Stall the CPU
    output logic         fetchDone,           // Instruction word ready
    output logic         loadDone,            // Load data ready
    output busCmd_t      cmd,                 // Command for the strobe
    output accessState_t state
);

    accessState_t stateNext;
    logic         prevBusy;                   // Busy one cycle ago
    logic         busyFall;                   // Memory just finished
    logic         pendingRead;                // Current data access is a load
    logic         dataAccess;                 // Data phase needs the bus

    // Falling-edge detector on busy
    always_ff @(posedge clk) begin
        if (!nrst) begin
            prevBusy <= 1'b0;
        end else begin
            prevBusy <= busy;
        end
    end

    assign busyFall   = prevBusy && !busy;
    assign dataAccess = memRead || memWrite;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state       <= Fetch;
            pendingRead <= 1'b0;
        end else begin
            state <= stateNext;
            if (state == Data) begin
                pendingRead <= memRead && !memWrite; // Store wins if both set
            end
        end
    end

    always_comb begin
        stateNext   = state;
        reqStrobe   = 1'b0;
        cmd         = RwiIdle;
        addrControl = 1'b0;
        freeze      = 1'b1;
        case (state)
            Fetch: begin
                reqStrobe = 1'b1;             // Fetch from PC
                cmd       = RwiFetch;
                freeze    = 1'b0;
                stateNext = FetchWait;
            end
            FetchWait: begin
                if (busyFall) begin
                    stateNext = Data;
                end
            end
            Data: begin
                addrControl = 1'b1;
                freeze      = dataAccess;     // Low if nothing to do
                if (memWrite) begin
                    reqStrobe = 1'b1;
                    cmd       = RwiWrite;
                    stateNext = DataWait;
                end else if (memRead) begin
                    reqStrobe = 1'b1;
                    cmd       = RwiRead;
                    stateNext = DataWait;
                end else begin
                    stateNext = Fetch;
                end
            end
            DataWait: begin
                addrControl = 1'b1;
                if (busyFall) begin
                    stateNext = Fetch;
                end
            end
            default: stateNext = Fetch;
        endcase
    end

    assign fetchDone = busyFall && (state == FetchWait);
    assign loadDone  = busyFall && (state == DataWait) && pendingRead; // Stores leave CPU result

    // A finished access must land in a wait state
    assert property (@(posedge clk) disable iff (!nrst)
        busyFall |-> (state == FetchWait || state == DataWait));

    // Only one request in flight at a time
    assert property (@(posedge clk) disable iff (!nrst) !(reqStrobe && busy));

endmodule

// File: verilog/dataLaneFormatter.sv
module dataLaneFormatter import memPkg::*; (
    input  logic   clk,
    input  logic   nrst,
    input  logic   fetchDone,                 // Capture instruction
    input  logic   loadDone,                  // Capture load result
    input  logic   memSource,                 // 1 FPU, 0 register file
    input  memOp_t memOp,
    input  word_t  fpuData,
    input  word_t  regData,
    input  word_t  readData,                  // Word from memory
    output word_t  writeData,                 // Formatted store data
    output word_t  instruction,
    output word_t  dataToCpu
);

    word_t storeSource;                       // Selected store operand
    word_t loadValue;                         // Extended load word

    assign storeSource = memSource ? fpuData : regData;

    // Store width cut, always zero-extended
    always_comb begin
        case (memOp)
            MemOpSb: writeData = {24'b0, storeSource[7:0]};
            MemOpSh: writeData = {16'b0, storeSource[15:0]};
            MemOpSw: writeData = storeSource;
            default: writeData = '0;          // Not a store
        endcase
    end

    // Load extension by opcode
    always_comb begin
        case (memOp)
            MemOpLb:  loadValue = {{24{readData[7]}}, readData[7:0]};
            MemOpLh:  loadValue = {{16{readData[15]}}, readData[15:0]};
            MemOpLw:  loadValue = readData;
            MemOpLbu: loadValue = {24'b0, readData[7:0]};
            MemOpLhu: loadValue = {16'b0, readData[15:0]};
            default:  loadValue = '0;         // Bad load op reads zero
        endcase
    end

    // Result registers toward the CPU
    always_ff @(posedge clk) begin
        if (!nrst) begin
            instruction <= '0;
            dataToCpu   <= '0;
        end else begin
            if (fetchDone) begin
                instruction <= readData;      // Raw fetch word
            end
            if (loadDone) begin
                dataToCpu <= loadValue;
            end
        end
    end

endmodule

// File: verilog/busRequestBuffer.sv
module busRequestBuffer import memPkg::*; (
    input  logic        clk,
    input  logic        nrst,
    input  logic        reqStrobe,            // New request this cycle
    input  busRequest_t reqIn,                // Combinational request from the mux
    output busRequest_t memReq,               // Held request toward memory
    output logic        memReqValid           // Pulse after capture
);

    // Payload holds until the next strobe
    always_ff @(posedge clk) begin
        if (reqStrobe) begin
            memReq <= reqIn;
        end
    end

    // Start pulse for the memory
    always_ff @(posedge clk) begin
        if (!nrst) begin
            memReqValid <= 1'b0;
        end else begin
            memReqValid <= reqStrobe;
        end
    end

    // Handler must never send an idle command
    assert property (@(posedge clk) disable iff (!nrst)
        memReqValid |-> (memReq.cmd != RwiIdle));

endmodule

// File: verilog/scratchpadMemory.sv
module scratchpadMemory import memPkg::*; (
    input  logic        clk,
    input  logic        nrst,
    input  logic        memReqValid,          // Start of a request
    input  busRequest_t memReq,               // Held request
    output logic        busy,                 // High MemLatency cycles
    output word_t       readData              // Word at request address
);

    word_t      memArray [MemDepthWords];     // Word storage
    latCount_t  busyCount;                    // Cycles left in access
    wordIndex_t reqIndex;                     // Word slot of request

    assign reqIndex = memReq.address[7:2];    // Byte offset dropped

    // Busy timer
    always_ff @(posedge clk) begin
        if (!nrst) begin
            busyCount <= '0;
        end else if (memReqValid) begin
            busyCount <= latCount_t'(MemLatency);
        end else if (busyCount != '0) begin
            busyCount <= busyCount - 1'b1;
        end
    end

    assign busy = (busyCount != '0);

    // Storage, written as busy rises
    always_ff @(posedge clk) begin
        if (!nrst) begin
            for (int i = 0; i < MemDepthWords; i++) begin
                memArray[i] <= '0;
            end
        end else if (memReqValid && (memReq.cmd == RwiWrite)) begin
            memArray[reqIndex] <= memReq.writeData; // Whole word store
        end
    end

    // Read and fetch share the same port
    // memReq stays put until the next strobe, so this is stable through busy
    assign readData = memArray[reqIndex];

    // One request at a time
    assert property (@(posedge clk) disable iff (!nrst) memReqValid |-> !busy);

endmodule

// File: verilog/memSubsystem.sv
module memSubsystem import memPkg::*; (
    input  logic   clk,
    input  logic   nrst,
    input  logic   memRead,
    input  logic   memWrite,
    input  logic   memSource,                 // Store data from FPU when set
    input  memOp_t memOp,
    input  word_t  pcAddress,                 // Fetch address
    input  word_t  aluAddress,                // Load/store address
    input  word_t  fpuData,
    input  word_t  regData,
    output logic   freeze,                    // CPU stall
    output word_t  instruction,
    output word_t  dataToCpu
);

    logic         reqStrobe;
    logic         addrControl;
    logic         fetchDone;
    logic         loadDone;
    logic         busy;
    logic         memReqValid;
    busCmd_t      cmd;
    word_t        writeData;                  // Formatted store word
    word_t        readData;                   // Memory output
    busRequest_t  reqIn;                      // Mux side request
    busRequest_t  memReq;                     // Registered request

    // Address mux and request assembly
    assign reqIn.cmd       = cmd;
    assign reqIn.address   = addrControl ? aluAddress : pcAddress;
    assign reqIn.writeData = writeData;

    memAccessFsm fsm_i (
        .clk, .nrst, .busy, .memRead, .memWrite,
        .reqStrobe, .addrControl, .freeze, .fetchDone, .loadDone,
        .cmd, .state()
    );

    dataLaneFormatter lane_i (
        .clk, .nrst, .fetchDone, .loadDone, .memSource, .memOp,
        .fpuData, .regData, .readData, .writeData, .instruction, .dataToCpu
    );

    busRequestBuffer buffer_i (.clk, .nrst, .reqStrobe, .reqIn, .memReq, .memReqValid);

    scratchpadMemory memory_i (.clk, .nrst, .memReqValid, .memReq, .busy, .readData);

endmodule

// File: verification/memSubsystemTb.sv
module memSubsystemTb import memPkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NumTests       = 17;
    localparam int CycleLimit     = 12;                          // Longest instruction cycle
    localparam int WatchdogCycles = CycleLimit * (NumTests + 2) * 2;
    localparam int MaxWaitCycles  = 2 * CycleLimit;              // Bound for one instruction

    // One table row, stimulus plus expected results
    typedef struct packed {
        memOp_t op;
        logic   rd;                                              // memRead
        logic   wr;                                              // memWrite
        logic   src;                                             // memSource
        word_t  pc;
        word_t  alu;
        word_t  fpuData;
        word_t  regData;
        word_t  expData;                                         // Expected dataToCpu
        word_t  expInstr;                                        // Expected instruction
    } testVec_t;

    logic   clk;
    logic   nrst;
    logic   memRead;
    logic   memWrite;
    logic   memSource;
    memOp_t memOp;
    word_t  pcAddress;
    word_t  aluAddress;
    word_t  fpuData;
    word_t  regData;
    logic   freeze;
    word_t  instruction;
    word_t  dataToCpu;

    testVec_t tests [NumTests];
    string    names [NumTests];
    word_t    refMem [MemDepthWords];                            // Model of the scratchpad
    word_t    lastLoad;                                          // Model of dataToCpu
    integer   seed;
    int       fillCount;
    int       passCount;
    int       failCount;

    memSubsystem dut_i (
        .clk, .nrst, .memRead, .memWrite, .memSource, .memOp,
        .pcAddress, .aluAddress, .fpuData, .regData,
        .freeze, .instruction, .dataToCpu
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;                                       // 40 ns period

    // Store rule: keep the low bytes, upper bits cleared
    function automatic word_t cutStore(memOp_t op, word_t src);
        case (op)
            MemOpSb: return src & 32'h0000_00ff;
            MemOpSh: return src & 32'h0000_ffff;
            MemOpSw: return src;
            default: return 32'h0;
        endcase
    endfunction

    // Load rule: signed ops copy the top selected bit upward
    function automatic word_t extendLoad(memOp_t op, word_t w);
        case (op)
            MemOpLb:  return w[7] ? (w | 32'hffff_ff00) : (w & 32'h0000_00ff);
            MemOpLh:  return w[15] ? (w | 32'hffff_0000) : (w & 32'h0000_ffff);
            MemOpLw:  return w;
            MemOpLbu: return w & 32'h0000_00ff;
            MemOpLhu: return w & 32'h0000_ffff;
            default:  return 32'h0;                              // Unknown op loads zero
        endcase
    endfunction

    task automatic addTest(input string name, input memOp_t op, input logic rd,
                           input logic wr, input logic src, input word_t pc,
                           input word_t alu, input word_t setBits);
        testVec_t t;
        t.op       = op;
        t.rd       = rd;
        t.wr       = wr;
        t.src      = src;
        t.pc       = pc;
        t.alu      = alu;
        t.fpuData  = $random(seed) | setBits;
        t.regData  = $random(seed) | setBits;
        t.expInstr = refMem[pc[7:2]];                            // Fetch runs before the store
        if (wr) begin
            refMem[alu[7:2]] = cutStore(op, src ? t.fpuData : t.regData);
        end else if (rd) begin
            lastLoad = extendLoad(op, refMem[alu[7:2]]);
        end
        t.expData        = lastLoad;                             // Stores keep the old result
        tests[fillCount] = t;
        names[fillCount] = name;
        fillCount++;
    endtask

    task automatic buildTable();
        for (int i = 0; i < MemDepthWords; i++) begin
            refMem[i] = 32'h0;                                   // Memory clears on reset
        end
        lastLoad  = 32'h0;
        fillCount = 0;
        //      name          op          rd    wr    src   pc          alu         setBits
        addTest("nopAfterReset", 4'd0,    1'b0, 1'b0, 1'b0, 32'h0000, 32'h0000, 32'h0);
        addTest("swReg",      MemOpSw,   1'b0, 1'b1, 1'b0, 32'h0004, 32'h0010, 32'h0);
        addTest("lwWordReg",  MemOpLw,   1'b1, 1'b0, 1'b0, 32'h0113, 32'h0010, 32'h0);
        addTest("shFpu",      MemOpSh,   1'b0, 1'b1, 1'b1, 32'h0008, 32'h0020, 32'h0);
        addTest("lwHalfFpu",  MemOpLw,   1'b1, 1'b0, 1'b0, 32'h000c, 32'h0020, 32'h0);
        addTest("sbReg",      MemOpSb,   1'b0, 1'b1, 1'b0, 32'h0020, 32'h0030, 32'h0);
        addTest("lwByteReg",  MemOpLw,   1'b1, 1'b0, 1'b0, 32'h0024, 32'h0030, 32'h0);
        addTest("sbFpu",      MemOpSb,   1'b0, 1'b1, 1'b1, 32'h0030, 32'h0034, 32'h0);
        addTest("lwByteFpu",  MemOpLw,   1'b1, 1'b0, 1'b0, 32'h0034, 32'h0034, 32'h0);
        addTest("swSignBits", MemOpSw,   1'b0, 1'b1, 1'b0, 32'h0038, 32'h0040, 32'h8080);
        addTest("lbSigned",   MemOpLb,   1'b1, 1'b0, 1'b0, 32'h003c, 32'h0040, 32'h0);
        addTest("lhSigned",   MemOpLh,   1'b1, 1'b0, 1'b0, 32'h0040, 32'h0040, 32'h0);
        addTest("lbuZero",    MemOpLbu,  1'b1, 1'b0, 1'b0, 32'h0044, 32'h0040, 32'h0);
        addTest("lhuZero",    MemOpLhu,  1'b1, 1'b0, 1'b0, 32'h0048, 32'h0040, 32'h0);
        addTest("swKeepsData", MemOpSw,  1'b0, 1'b1, 1'b0, 32'h004c, 32'h0044, 32'h0);
        addTest("badLoadOp",  4'hf,      1'b1, 1'b0, 1'b0, 32'h0050, 32'h0040, 32'h0);
        addTest("fetchStored", 4'd0,     1'b0, 1'b0, 1'b0, 32'h0347, 32'h0000, 32'h0);
    endtask

    task automatic applyControls(input testVec_t t);
        memOp      = t.op;
        memRead    = t.rd;
        memWrite   = t.wr;
        memSource  = t.src;
        pcAddress  = t.pc;
        aluAddress = t.alu;
        fpuData    = t.fpuData;
        regData    = t.regData;
    endtask

    // Ends on the falling edge inside the next Fetch
    task automatic waitCycleEnd(input testVec_t t, output bit done);
        logic prevFreeze;
        int   n;
        prevFreeze = 1'b0;                                       // Fetch runs with freeze low
        done       = 1'b0;
        n          = 0;
        while (!done && n < MaxWaitCycles) begin
            @(negedge clk);
            done       = prevFreeze && !freeze;
            prevFreeze = freeze;
            n++;
        end
        if (done && !(t.rd || t.wr)) begin
            @(negedge clk);                                      // Idle data phase still to pass
        end
    endtask

    task automatic checkReset();
        assert (instruction === 32'h0 && dataToCpu === 32'h0) begin
            passCount++;
            $display("PASS resetValues");
        end else begin
            failCount++;
            $display("Mismatch resetValues: exp instr %h data %h, got instr %h data %h",
                     32'h0, 32'h0, instruction, dataToCpu);
        end
    endtask

    task automatic checkResult(input int idx);
        testVec_t t;
        t = tests[idx];
        assert (freeze === 1'b0 && instruction === t.expInstr && dataToCpu === t.expData) begin
            passCount++;
            $display("PASS %s", names[idx]);
        end else begin
            failCount++;
            $display("Mismatch %s: exp instr %h data %h, got instr %h data %h freeze %b",
                     names[idx], t.expInstr, t.expData, instruction, dataToCpu, freeze);
        end
    endtask

    initial begin
        bit done;
        seed       = 84;
        passCount  = 0;
        failCount  = 0;
        nrst       = 1'b0;
        memRead    = 1'b0;
        memWrite   = 1'b0;
        memSource  = 1'b0;
        memOp      = 4'd0;
        pcAddress  = 32'h0;
        aluAddress = 32'h0;
        fpuData    = 32'h0;
        regData    = 32'h0;
        buildTable();
        repeat (4) @(posedge clk);
        @(negedge clk);
        checkReset();
        nrst = 1'b1;                                             // FSM sits in Fetch here
        for (int i = 0; i < NumTests; i++) begin
            applyControls(tests[i]);
            waitCycleEnd(tests[i], done);
            if (done) begin
                checkResult(i);
            end else begin
                failCount++;
                $display("Test %s: freeze never fell within %0d cycles", names[i],
                         MaxWaitCycles);
            end
        end
        $display("Summary: %0d tests, %0d passed, %0d failed", NumTests + 1, passCount,
                 failCount);
        if (failCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WatchdogCycles) @(posedge clk);
        $display("Watchdog timeout: run still going after %0d clock cycles", WatchdogCycles);
        $display("Regression failed");
        $finish;
    end

endmodule

// File: memSubsystem.f
verilog/memPkg.sv
verilog/memAccessFsm.sv
verilog/dataLaneFormatter.sv
verilog/busRequestBuffer.sv
verilog/scratchpadMemory.sv
verilog/memSubsystem.sv
verification/memSubsystemTb.sv

// File: Bender.yml
package:
  name: memsubsystem

sources:
  # Package first, then the leaf modules, then the top level
  - files:
      - verilog/memPkg.sv
      - verilog/memAccessFsm.sv
      - verilog/dataLaneFormatter.sv
      - verilog/busRequestBuffer.sv
      - verilog/scratchpadMemory.sv
      - verilog/memSubsystem.sv

  # Testbench, only for simulation
  - target: test
    files:
      - verification/memSubsystemTb.sv
